// File: src/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Widths
`define CSR_NUM_W       14
`define CSR_DATA_W      32
`define IS_W            13

// Register numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00C
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// Exception codes
`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUBCODE_ADEF   9'h000

// Field masks
`define ECFG_LIE_MASK   13'h1BFF
`define EENTRY_VA_MASK  32'hFFFF_FFC0
`define TICLR_CLR_BIT   0

// Timer count when stopped
`define TIMER_IDLE      32'hFFFF_FFFF

`endif

// File: src/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic        rsvd_hi;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  rsvd_lo;
        logic [12:0] is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // One register word, seen through the layout of its target
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_t                  crmd_f;
        prmd_t                  prmd_f;
        estat_t                 estat_f;
        tcfg_t                  tcfg_f;
    } csr_word_u;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] mask;
        csr_word_u              value;
    } csr_write_t;

    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ecfg;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
        logic       tcfg;
        logic       ticlr;
    } csr_sel_t;

    typedef struct packed {
        logic                   ex;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_event_t;

    // Masked bits from the write value, the rest from the old value
    function automatic logic [`CSR_DATA_W-1:0] csr_merge(
        input csr_write_t             w,
        input logic [`CSR_DATA_W-1:0] old
    );
        return (w.mask & w.value.raw) | (~w.mask & old);
    endfunction

endpackage

// File: src/csr_access_ctrl.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_access_ctrl import csr_pkg::*; (
    input  logic [`CSR_NUM_W-1:0] csr_num,
    input  logic                  csr_we,
    input  csr_word_u             crmd_rd,
    input  csr_word_u             prmd_rd,
    input  csr_word_u             era_rd,
    input  csr_word_u             eentry_rd,
    input  csr_word_u             badv_rd,
    input  csr_word_u             save_rd [4],
    input  csr_word_u             exc_cause_rd,
    input  csr_word_u             is_rd,
    input  csr_word_u             ecfg_rd,
    input  csr_word_u             tcfg_rd,
    input  csr_word_u             tval_rd,
    output csr_sel_t              wr_sel,
    output csr_word_u             csr_rvalue
);
    csr_word_u estat_rd;

    // Cause fields and pending bits sit in disjoint bit ranges
    assign estat_rd.raw = exc_cause_rd.raw | is_rd.raw;

    always_comb begin
        wr_sel = '0;
        if (csr_we) begin
            case (csr_num)
                `CSR_CRMD:   wr_sel.crmd    = 1'b1;
                `CSR_PRMD:   wr_sel.prmd    = 1'b1;
                `CSR_ECFG:   wr_sel.ecfg    = 1'b1;
                `CSR_ESTAT:  wr_sel.estat   = 1'b1;
                `CSR_ERA:    wr_sel.era     = 1'b1;
                `CSR_BADV:   wr_sel.badv    = 1'b1;
                `CSR_EENTRY: wr_sel.eentry  = 1'b1;
                `CSR_SAVE0:  wr_sel.save[0] = 1'b1;
                `CSR_SAVE1:  wr_sel.save[1] = 1'b1;
                `CSR_SAVE2:  wr_sel.save[2] = 1'b1;
                `CSR_SAVE3:  wr_sel.save[3] = 1'b1;
                `CSR_TCFG:   wr_sel.tcfg    = 1'b1;
                `CSR_TICLR:  wr_sel.ticlr   = 1'b1;
                default:     wr_sel         = '0;
            endcase
        end
    end

    // Read word for the number presented
    always_comb begin
        case (csr_num)
            `CSR_CRMD:   csr_rvalue = crmd_rd;
            `CSR_PRMD:   csr_rvalue = prmd_rd;
            `CSR_ECFG:   csr_rvalue = ecfg_rd;
            `CSR_ESTAT:  csr_rvalue = estat_rd;
            `CSR_ERA:    csr_rvalue = era_rd;
            `CSR_BADV:   csr_rvalue = badv_rd;
            `CSR_EENTRY: csr_rvalue = eentry_rd;
            `CSR_SAVE0:  csr_rvalue = save_rd[0];
            `CSR_SAVE1:  csr_rvalue = save_rd[1];
            `CSR_SAVE2:  csr_rvalue = save_rd[2];
            `CSR_SAVE3:  csr_rvalue = save_rd[3];
            `CSR_TCFG:   csr_rvalue = tcfg_rd;
            `CSR_TVAL:   csr_rvalue = tval_rd;
            `CSR_TICLR:  csr_rvalue = '0;
            default:     csr_rvalue = '0;
        endcase
    end

endmodule

// File: src/exc_state_regs.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module exc_state_regs import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  csr_sel_t               wr_sel,
    input  csr_write_t             wr,
    input  exc_event_t             exc,
    input  logic                   ertn_flush,
    output csr_word_u              crmd_rd,
    output csr_word_u              prmd_rd,
    output csr_word_u              era_rd,
    output csr_word_u              eentry_rd,
    output csr_word_u              badv_rd,
    output csr_word_u              save_rd [4],
    output csr_word_u              exc_cause_rd,
    output logic                   crmd_ie,
    output logic [`CSR_DATA_W-1:0] ex_entry
);
    logic [1:0]             crmd_plv;
    logic [1:0]             prmd_pplv;
    logic                   prmd_pie;
    logic [5:0]             ecode;
    logic [8:0]             esubcode;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] save [4];
    logic                   addr_err;
    csr_word_u              crmd_nx;
    csr_word_u              prmd_nx;

    assign crmd_nx.raw = csr_merge(wr, crmd_rd.raw);
    assign prmd_nx.raw = csr_merge(wr, prmd_rd.raw);
    assign addr_err    = (exc.ecode == `ECODE_ADE) || (exc.ecode == `ECODE_ALE);

    // Entry beats return, return beats a software write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_sel.crmd) begin
            crmd_plv <= crmd_nx.crmd_f.plv;
            crmd_ie  <= crmd_nx.crmd_f.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
            era       <= '0;
            ecode     <= 6'b0;
            esubcode  <= 9'b0;
            badv      <= '0;
        end else if (exc.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era       <= exc.pc;
            ecode     <= exc.ecode;
            esubcode  <= exc.esubcode;
            // Fetch faults report the pc, data faults the address
            if (addr_err) begin
                badv <= (exc.ecode == `ECODE_ADE && exc.esubcode == `ESUBCODE_ADEF) ?
                        exc.pc : exc.vaddr;
            end
        end else begin
            if (wr_sel.prmd) begin
                prmd_pplv <= prmd_nx.prmd_f.pplv;
                prmd_pie  <= prmd_nx.prmd_f.pie;
            end
            if (wr_sel.era) begin
                era <= csr_merge(wr, era);
            end
            if (wr_sel.badv) begin
                badv <= csr_merge(wr, badv);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else begin
            if (wr_sel.eentry) begin
                eentry <= csr_merge(wr, eentry) & `EENTRY_VA_MASK;
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_sel.save[i]) begin
                    save[i] <= csr_merge(wr, save[i]);
                end
            end
        end
    end

    always_comb begin
        crmd_rd              = '0;
        crmd_rd.crmd_f.plv   = crmd_plv;
        crmd_rd.crmd_f.ie    = crmd_ie;
        // Direct address translation only
        crmd_rd.crmd_f.da    = 1'b1;
        prmd_rd              = '0;
        prmd_rd.prmd_f.pplv  = prmd_pplv;
        prmd_rd.prmd_f.pie   = prmd_pie;
        exc_cause_rd                  = '0;
        exc_cause_rd.estat_f.ecode    = ecode;
        exc_cause_rd.estat_f.esubcode = esubcode;
        for (int i = 0; i < 4; i++) begin
            save_rd[i].raw = save[i];
        end
    end

    assign era_rd.raw    = era;
    assign eentry_rd.raw = eentry;
    assign badv_rd.raw   = badv;
    assign ex_entry      = eentry;

endmodule

// File: src/int_status.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module int_status import csr_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  csr_sel_t   wr_sel,
    input  csr_write_t wr,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    input  logic       timer_fire,
    input  logic       crmd_ie,
    output csr_word_u  is_rd,
    output csr_word_u  ecfg_rd,
    output logic       has_int
);
    logic [1:0]             is_sw;
    logic [7:0]             is_hw;
    logic                   is_ti;
    logic                   is_ipi;
    logic [`IS_W-1:0]       lie;
    logic [`IS_W-1:0]       is_all;
    logic [`CSR_DATA_W-1:0] ecfg_nx;
    logic                   ticlr_hit;
    csr_word_u              estat_nx;

    assign estat_nx.raw = csr_merge(wr, is_rd.raw);
    assign ecfg_nx      = csr_merge(wr, ecfg_rd.raw);
    assign ticlr_hit    = wr_sel.ticlr && wr.mask[`TICLR_CLR_BIT]
                          && wr.value.raw[`TICLR_CLR_BIT];

    // IS[10] is reserved and reads zero
    assign is_all = {is_ipi, is_ti, 1'b0, is_hw, is_sw};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            is_sw  <= 2'b0;
            is_hw  <= 8'b0;
            is_ipi <= 1'b0;
            is_ti  <= 1'b0;
            lie    <= '0;
        end else begin
            is_hw  <= hw_int_in;
            is_ipi <= ipi_int_in;
            if (wr_sel.estat) begin
                is_sw <= estat_nx.estat_f.is[1:0];
            end
            // Timer pending wins over a clear in the same cycle
            if (timer_fire) begin
                is_ti <= 1'b1;
            end else if (ticlr_hit) begin
                is_ti <= 1'b0;
            end
            if (wr_sel.ecfg) begin
                lie <= ecfg_nx[`IS_W-1:0] & `ECFG_LIE_MASK;
            end
        end
    end

    always_comb begin
        is_rd            = '0;
        is_rd.estat_f.is = is_all;
        ecfg_rd          = '0;
        ecfg_rd.raw[`IS_W-1:0] = lie;
    end

    assign has_int = (|(is_all & lie)) && crmd_ie;

endmodule

// File: src/timer_unit.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module timer_unit import csr_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  csr_sel_t   wr_sel,
    input  csr_write_t wr,
    output csr_word_u  tcfg_rd,
    output csr_word_u  tval_rd,
    output logic       timer_fire
);
    logic                   en;
    logic                   periodic;
    logic [29:0]            initval;
    logic [`CSR_DATA_W-1:0] cnt;
    csr_word_u              tcfg_nx;

    assign tcfg_nx.raw = csr_merge(wr, tcfg_rd.raw);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
        end else if (wr_sel.tcfg) begin
            en       <= tcfg_nx.tcfg_f.en;
            periodic <= tcfg_nx.tcfg_f.periodic;
            initval  <= tcfg_nx.tcfg_f.initval;
        end
    end

    // Count parks at all ones once a one-shot run passes zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= `TIMER_IDLE;
        end else if (wr_sel.tcfg && tcfg_nx.tcfg_f.en) begin
            cnt <= {tcfg_nx.tcfg_f.initval, 2'b00};
        end else if (en && cnt != `TIMER_IDLE) begin
            if (cnt == '0 && periodic) begin
                cnt <= {initval, 2'b00};
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign tcfg_rd.tcfg_f = '{initval: initval, periodic: periodic, en: en};
    assign tval_rd.raw    = cnt;
    assign timer_fire     = en && (cnt == '0);

endmodule

// File: src/csr_file.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_file import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    input  logic                   csr_we,
    input  csr_write_t             wr,
    input  exc_event_t             exc,
    input  logic                   ertn_flush,
    input  logic [7:0]             hw_int_in,
    input  logic                   ipi_int_in,
    output csr_word_u              csr_rvalue,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic                   has_int
);
    csr_sel_t  wr_sel;
    csr_word_u crmd_rd;
    csr_word_u prmd_rd;
    csr_word_u era_rd;
    csr_word_u eentry_rd;
    csr_word_u badv_rd;
    csr_word_u save_rd [4];
    csr_word_u exc_cause_rd;
    csr_word_u is_rd;
    csr_word_u ecfg_rd;
    csr_word_u tcfg_rd;
    csr_word_u tval_rd;
    logic      crmd_ie;
    logic      timer_fire;

    csr_access_ctrl u_access_ctrl (
        .csr_num      (csr_num),
        .csr_we       (csr_we),
        .crmd_rd      (crmd_rd),
        .prmd_rd      (prmd_rd),
        .era_rd       (era_rd),
        .eentry_rd    (eentry_rd),
        .badv_rd      (badv_rd),
        .save_rd      (save_rd),
        .exc_cause_rd (exc_cause_rd),
        .is_rd        (is_rd),
        .ecfg_rd      (ecfg_rd),
        .tcfg_rd      (tcfg_rd),
        .tval_rd      (tval_rd),
        .wr_sel       (wr_sel),
        .csr_rvalue   (csr_rvalue)
    );

    exc_state_regs u_exc_state (
        .clk          (clk),
        .resetn       (resetn),
        .wr_sel       (wr_sel),
        .wr           (wr),
        .exc          (exc),
        .ertn_flush   (ertn_flush),
        .crmd_rd      (crmd_rd),
        .prmd_rd      (prmd_rd),
        .era_rd       (era_rd),
        .eentry_rd    (eentry_rd),
        .badv_rd      (badv_rd),
        .save_rd      (save_rd),
        .exc_cause_rd (exc_cause_rd),
        .crmd_ie      (crmd_ie),
        .ex_entry     (ex_entry)
    );

    int_status u_int_status (
        .clk        (clk),
        .resetn     (resetn),
        .wr_sel     (wr_sel),
        .wr         (wr),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_fire (timer_fire),
        .crmd_ie    (crmd_ie),
        .is_rd      (is_rd),
        .ecfg_rd    (ecfg_rd),
        .has_int    (has_int)
    );

    timer_unit u_timer (
        .clk        (clk),
        .resetn     (resetn),
        .wr_sel     (wr_sel),
        .wr         (wr),
        .tcfg_rd    (tcfg_rd),
        .tval_rd    (tval_rd),
        .timer_fire (timer_fire)
    );

endmodule

// File: bench/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Expected register state after each rising edge
logic [1:0]  m_plv;
logic        m_ie;
logic [1:0]  m_pplv;
logic        m_pie;
logic [5:0]  m_ecode;
logic [8:0]  m_esub;
logic [31:0] m_era;
logic [31:0] m_eentry;
logic [31:0] m_badv;
logic [31:0] m_save [4];
logic [1:0]  m_is_sw;
logic [7:0]  m_is_hw;
logic        m_is_ti;
logic        m_is_ipi;
logic [12:0] m_lie;
logic        m_en;
logic        m_periodic;
logic [29:0] m_initval;
logic [31:0] m_cnt;

function automatic logic [31:0] apply_mask(input logic [31:0] old);
    return (wr.mask & wr.value.raw) | (~wr.mask & old);
endfunction

function automatic logic [12:0] pending_bits();
    return {m_is_ipi, m_is_ti, 1'b0, m_is_hw, m_is_sw};
endfunction

function automatic csr_word_u expected_read(input logic [`CSR_NUM_W-1:0] num);
    csr_word_u w;
    w.raw = '0;
    case (num)
        // DA is fixed at 1
        `CSR_CRMD:   w.raw = {28'd0, 1'b1, m_ie, m_plv};
        `CSR_PRMD:   w.raw = {29'd0, m_pie, m_pplv};
        `CSR_ECFG:   w.raw = {19'd0, m_lie};
        `CSR_ESTAT:  w.raw = {1'b0, m_esub, m_ecode, 3'd0, pending_bits()};
        `CSR_ERA:    w.raw = m_era;
        `CSR_BADV:   w.raw = m_badv;
        `CSR_EENTRY: w.raw = m_eentry;
        `CSR_SAVE0:  w.raw = m_save[0];
        `CSR_SAVE1:  w.raw = m_save[1];
        `CSR_SAVE2:  w.raw = m_save[2];
        `CSR_SAVE3:  w.raw = m_save[3];
        `CSR_TCFG:   w.raw = {m_initval, m_periodic, m_en};
        `CSR_TVAL:   w.raw = m_cnt;
        default:     w.raw = '0;
    endcase
    return w;
endfunction

function automatic logic expected_has_int();
    return (|(pending_bits() & m_lie)) && m_ie;
endfunction

task automatic update_model();
    csr_word_u   cur;
    logic [31:0] v;
    logic        fire;
    logic        old_en;
    logic        old_per;
    logic [29:0] old_init;
    logic [1:0]  old_plv;
    logic        old_ie;
    if (!resetn) begin
        {m_plv, m_ie, m_pplv, m_pie, m_ecode, m_esub} = '0;
        {m_era, m_eentry, m_badv} = '0;
        {m_is_sw, m_is_hw, m_is_ti, m_is_ipi, m_lie} = '0;
        {m_en, m_periodic, m_initval} = '0;
        m_cnt = 32'hFFFF_FFFF;
        for (int k = 0; k < 4; k++) begin
            m_save[k] = '0;
        end
    end else begin
        cur      = expected_read(csr_num);
        v        = apply_mask(cur.raw);
        fire     = m_en && (m_cnt == 32'd0);
        old_en   = m_en;
        old_per  = m_periodic;
        old_init = m_initval;
        old_plv  = m_plv;
        old_ie   = m_ie;
        if (exc.ex) begin
            m_plv   = 2'd0;
            m_ie    = 1'b0;
            m_pplv  = old_plv;
            m_pie   = old_ie;
            m_era   = exc.pc;
            m_ecode = exc.ecode;
            m_esub  = exc.esubcode;
            if (exc.ecode == `ECODE_ADE && exc.esubcode == `ESUBCODE_ADEF)
                m_badv = exc.pc;
            else if (exc.ecode == `ECODE_ADE || exc.ecode == `ECODE_ALE)
                m_badv = exc.vaddr;
        end else if (ertn_flush) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end
        if (csr_we) begin
            case (csr_num)
                `CSR_CRMD: begin
                    if (!exc.ex && !ertn_flush) begin
                        m_plv = v[1:0];
                        m_ie  = v[2];
                    end
                end
                `CSR_PRMD: begin
                    if (!exc.ex) begin
                        m_pplv = v[1:0];
                        m_pie  = v[2];
                    end
                end
                `CSR_ERA:    m_era = exc.ex ? m_era : v;
                `CSR_BADV:   m_badv = exc.ex ? m_badv : v;
                `CSR_EENTRY: m_eentry = {v[31:6], 6'd0};
                `CSR_SAVE0:  m_save[0] = v;
                `CSR_SAVE1:  m_save[1] = v;
                `CSR_SAVE2:  m_save[2] = v;
                `CSR_SAVE3:  m_save[3] = v;
                `CSR_ESTAT:  m_is_sw = v[1:0];
                `CSR_ECFG:   m_lie = v[12:0] & `ECFG_LIE_MASK;
                `CSR_TCFG: begin
                    m_en       = v[0];
                    m_periodic = v[1];
                    m_initval  = v[31:2];
                end
                default: ;
            endcase
        end
        if (csr_we && csr_num == `CSR_TCFG && v[0])
            m_cnt = {v[31:2], 2'b00};
        else if (old_en && m_cnt != 32'hFFFF_FFFF)
            m_cnt = (m_cnt == 32'd0 && old_per) ? {old_init, 2'b00} : m_cnt - 32'd1;
        if (fire)
            m_is_ti = 1'b1;
        else if (csr_we && csr_num == `CSR_TICLR && wr.mask[0] && wr.value.raw[0])
            m_is_ti = 1'b0;
        m_is_hw  = hw_int_in;
        m_is_ipi = ipi_int_in;
    end
endtask

`endif

// File: bench/csr_file_tb.sv
`timescale 1ns/1ns
`include "csr_params.svh"

module csr_file_tb import csr_pkg::*; ();
    localparam int N_RANDOM   = 400;
    localparam int TIMER_WAIT = 64;

    logic                   clk;
    logic                   resetn;
    logic [`CSR_NUM_W-1:0]  csr_num;
    logic                   csr_we;
    csr_write_t             wr;
    exc_event_t             exc;
    logic                   ertn_flush;
    logic [7:0]             hw_int_in;
    logic                   ipi_int_in;
    csr_word_u              csr_rvalue;
    logic [`CSR_DATA_W-1:0] ex_entry;
    logic                   has_int;

    integer seed;
    int     errors;
    int     checks;
    int     test_errs;

    logic [`CSR_NUM_W-1:0] impl_nums [14] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR
    };

    `include "csr_model.svh"

    csr_file uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = rand32();
        return (r % 100) < pct;
    endfunction

    // Mostly implemented numbers, now and then any number
    function automatic logic [`CSR_NUM_W-1:0] pick_num();
        logic [31:0] r;
        int          idx;
        r = rand32();
        if (r[3:0] == 4'd0)
            return r[17:4];
        idx = r[7:4] % 14;
        return impl_nums[idx];
    endfunction

    task automatic check_word(input string name, input csr_word_u got, input csr_word_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("Timeout at t=%0t while waiting for %s", $time, what);
    endtask

    task automatic report_test(input string name);
        if (errors == test_errs)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    task automatic tick();
        @(posedge clk);
        update_model();
        #1;
    endtask

    task automatic settle_and_check();
        #10;
        check_word("csr_rvalue", csr_rvalue, expected_read(csr_num));
        check_bit("has_int", has_int, expected_has_int());
        check_word("ex_entry", ex_entry, expected_read(`CSR_EENTRY));
    endtask

    task automatic drive_idle();
        csr_we     = 1'b0;
        csr_num    = '0;
        wr         = '0;
        exc        = '0;
        ertn_flush = 1'b0;
        hw_int_in  = 8'd0;
        ipi_int_in = 1'b0;
    endtask

    task automatic drive_random(input int we_pct, input int ex_pct, input int ertn_pct);
        logic [31:0] r;
        csr_num      = pick_num();
        csr_we       = chance(we_pct);
        wr.mask      = rand32();
        wr.value.raw = rand32();
        exc.ex       = chance(ex_pct);
        r = rand32();
        case (r[1:0])
            2'd0:    exc.ecode = `ECODE_ADE;
            2'd1:    exc.ecode = `ECODE_ALE;
            default: exc.ecode = r[7:2];
        endcase
        exc.esubcode = r[8] ? `ESUBCODE_ADEF : r[17:9];
        exc.pc       = rand32();
        exc.vaddr    = rand32();
        ertn_flush   = chance(ertn_pct);
        r = rand32();
        hw_int_in  = r[7:0];
        ipi_int_in = r[8];
    endtask

    task automatic write_reg(input logic [`CSR_NUM_W-1:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        drive_idle();
        csr_num      = num;
        csr_we       = 1'b1;
        wr.mask      = mask;
        wr.value.raw = value;
        settle_and_check();
        tick();
        csr_we = 1'b0;
    endtask

    initial begin
        int        n;
        int        reloads;
        logic      done;
        csr_word_u exp_val;
        seed      = 42;
        errors    = 0;
        checks    = 0;
        test_errs = 0;
        clk       = 1'b0;
        resetn    = 1'b0;
        drive_idle();
        repeat (3) tick();
        resetn = 1'b1;

        for (int i = 0; i < N_RANDOM; i++) begin
            drive_random(60, 0, 0);
            settle_and_check();
            tick();
        end
        report_test("masked writes");

        for (int i = 0; i < N_RANDOM; i++) begin
            drive_random(20, 25, 20);
            case (i % 4)
                0:       csr_num = `CSR_CRMD;
                1:       csr_num = `CSR_PRMD;
                2:       csr_num = `CSR_ERA;
                default: csr_num = `CSR_ESTAT;
            endcase
            settle_and_check();
            tick();
        end
        report_test("exception entry and return");

        for (int i = 0; i < N_RANDOM; i++) begin
            drive_random(10, 50, 0);
            if (i % 2 == 0)
                csr_num = `CSR_BADV;
            settle_and_check();
            tick();
        end
        report_test("badv select");

        // INITVAL 3 gives a count of 12
        write_reg(`CSR_TCFG, 32'hFFFF_FFFF, 32'h0);
        write_reg(`CSR_TICLR, 32'h1, 32'h1);
        write_reg(`CSR_TCFG, 32'hFFFF_FFFF, {30'd3, 1'b0, 1'b1});
        csr_num     = `CSR_TVAL;
        exp_val.raw = 32'd12;
        done        = 1'b0;
        n           = 0;
        while (!done && n < TIMER_WAIT) begin
            settle_and_check();
            check_word("tval", csr_rvalue, exp_val);
            done = (csr_rvalue.raw == `TIMER_IDLE);
            exp_val.raw = (exp_val.raw == 32'd0) ? `TIMER_IDLE : exp_val.raw - 32'd1;
            tick();
            n++;
        end
        if (!done)
            note_timeout("TVAL to stop at all ones");
        exp_val.raw = `TIMER_IDLE;
        repeat (3) begin
            settle_and_check();
            check_word("tval", csr_rvalue, exp_val);
            tick();
        end
        csr_num = `CSR_ESTAT;
        settle_and_check();
        check_bit("estat.is[11]", csr_rvalue.estat_f.is[11], 1'b1);
        write_reg(`CSR_TICLR, 32'h1, 32'h1);
        csr_num = `CSR_ESTAT;
        settle_and_check();
        check_bit("estat.is[11]", csr_rvalue.estat_f.is[11], 1'b0);
        tick();
        report_test("one-shot timer");

        // Periodic with INITVAL 2, so the count runs 8 down to 0
        write_reg(`CSR_TCFG, 32'hFFFF_FFFF, {30'd2, 1'b1, 1'b1});
        csr_num     = `CSR_TVAL;
        exp_val.raw = 32'd8;
        reloads     = 0;
        n           = 0;
        while (reloads == 0 && n < TIMER_WAIT) begin
            settle_and_check();
            check_word("tval", csr_rvalue, exp_val);
            if (n > 0 && csr_rvalue.raw == 32'd8)
                reloads++;
            exp_val.raw = (exp_val.raw == 32'd0) ? 32'd8 : exp_val.raw - 32'd1;
            tick();
            n++;
        end
        if (reloads == 0)
            note_timeout("TVAL to reload");
        csr_num = `CSR_ESTAT;
        settle_and_check();
        check_bit("estat.is[11]", csr_rvalue.estat_f.is[11], 1'b1);
        write_reg(`CSR_TICLR, 32'h1, 32'h1);
        csr_num = `CSR_ESTAT;
        settle_and_check();
        check_bit("estat.is[11]", csr_rvalue.estat_f.is[11], 1'b0);
        tick();
        done = 1'b0;
        n    = 0;
        while (!done && n < TIMER_WAIT) begin
            settle_and_check();
            done = csr_rvalue.estat_f.is[11];
            tick();
            n++;
        end
        if (!done)
            note_timeout("IS[11] to set again");
        write_reg(`CSR_TCFG, 32'hFFFF_FFFF, 32'h0);
        report_test("periodic timer");

        for (int i = 0; i < N_RANDOM; i++) begin
            drive_random(50, 0, 0);
            case (i % 3)
                0:       csr_num = `CSR_ESTAT;
                1:       csr_num = `CSR_ECFG;
                default: csr_num = `CSR_CRMD;
            endcase
            settle_and_check();
            tick();
        end
        report_test("interrupt request");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
+incdir+bench
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/exc_state_regs.sv
src/int_status.sv
src/timer_unit.sv
src/csr_file.sv
bench/csr_file_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module csr_file_tb \
    --Mdir obj_dir -o csr_sim
./obj_dir/csr_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
